/* project.f */
source/hdc_cfg_pkg.sv
source/hdc_types_pkg.sv
source/mem_bus_if.sv
source/item_memory.sv
source/mem_arbiter.sv
source/hv_encode_core.sv
source/hv_batch_ctrl.sv
source/hv_bundle_counter.sv
source/hv_bundler.sv
source/hdc_encoder_top.sv
bench/tb_hdc_encoder.sv

/* bench/tb_hdc_encoder.sv */
`timescale 1ns/1ps

module tb_hdc_encoder import hdc_cfg_pkg::*; ();

    // row kinds of the stimulus table
    typedef enum logic [1:0] {
        k_load, k_batch, k_finish
    } row_kind_t;

    // one stimulus row, lane 0 in the low slice
    typedef struct packed {
        row_kind_t                        kind;
        logic [num_cores-1:0][sym_w-1:0]   syms;
        logic [num_cores-1:0][shift_w-1:0] shifts;
        logic [num_cores-1:0]              mask;
        logic                              bp;
    } row_t;

    localparam int num_rows = 14;
    // about twenty cycles per row plus slack for reset and loading
    localparam int max_cycles = 20 * num_rows + 200;

    logic clk;
    logic rst_n;
    logic load_en;
    logic [sym_w-1:0] load_addr;
    logic [hv_dim-1:0] load_data;
    logic sample_req;
    logic sample_ack;
    logic [num_cores-1:0][sym_w-1:0] sample_symbols;
    logic [num_cores-1:0][shift_w-1:0] sample_shifts;
    logic [num_cores-1:0] sample_mask;
    logic finish_req;
    logic finish_ack;
    logic [stream_w-1:0] stream_data;
    logic stream_valid;
    logic stream_last;
    logic stream_ready;

    integer seed = 21621;
    int cycle_cnt = 0;
    row_t table_rows [num_rows];

    // reference copy of the item memory and the vote counters
    logic [hv_dim-1:0] model_mem [num_items];
    int model_cnt [hv_dim];

    hdc_encoder_top u_hdc_encoder_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .sample_req     (sample_req),
        .sample_ack     (sample_ack),
        .sample_symbols (sample_symbols),
        .sample_shifts  (sample_shifts),
        .sample_mask    (sample_mask),
        .finish_req     (finish_req),
        .finish_ack     (finish_ack),
        .stream_data    (stream_data),
        .stream_valid   (stream_valid),
        .stream_last    (stream_last),
        .stream_ready   (stream_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // hang guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("run timed out after %0d cycles without finishing", cycle_cnt);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [hv_dim-1:0] actual,
                               input logic [hv_dim-1:0] expected);
        if (actual !== expected) begin
            $display("Error %s got 0x%0h expected 0x%0h", name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    function automatic row_t make_row(input row_kind_t kind,
                                      input logic [num_cores-1:0][sym_w-1:0] syms,
                                      input logic [num_cores-1:0][shift_w-1:0] shifts,
                                      input logic [num_cores-1:0] mask, input logic bp);
        row_t r;
        r.kind = kind;
        r.syms = syms;
        r.shifts = shifts;
        r.mask = mask;
        r.bp = bp;
        return r;
    endfunction

    // random ready under back-pressure, else always ready
    function automatic logic next_ready(input logic bp);
        int r;
        r = $random(seed);
        return bp ? r[0] : 1'b1;
    endfunction

    // random items, item 15 the complement of item 14 for cancelling votes
    task automatic load_items();
        logic [31:0] hi;
        logic [31:0] lo;
        for (int a = 0; a < num_items; a++) begin
            hi = $random(seed);
            lo = $random(seed);
            model_mem[a] = (a == num_items - 1) ? ~model_mem[a-1] : {hi, lo};
            @(posedge clk);
            load_en <= 1'b1;
            load_addr <= sym_w'(a);
            load_data <= model_mem[a];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // rotate left, vote per stored lane, saturate once per store
    task automatic model_batch(input row_t r);
        logic [hv_dim-1:0] item;
        int sum;
        int src;
        for (int j = 0; j < hv_dim; j++) begin
            sum = model_cnt[j];
            for (int i = 0; i < num_cores; i++) begin
                if (r.mask[i]) begin
                    item = model_mem[r.syms[i]];
                    // bit j of the rotated item came from bit j - shift
                    src = (j - int'(r.shifts[i]) + hv_dim) % hv_dim;
                    sum = sum + (item[src] ? 1 : -1);
                end
            end
            if (sum > cnt_max) begin
                sum = cnt_max;
            end else if (sum < cnt_min) begin
                sum = cnt_min;
            end
            model_cnt[j] = sum;
        end
    endtask

    task automatic run_batch(input row_t r);
        @(posedge clk);
        sample_symbols <= r.syms;
        sample_shifts <= r.shifts;
        sample_mask <= r.mask;
        sample_req <= 1'b1;
        do @(negedge clk); while (!sample_ack);
        @(posedge clk);
        sample_req <= 1'b0;
        do @(negedge clk); while (sample_ack);
        model_batch(r);
    endtask

    task automatic run_finish(input logic bp);
        logic [stream_w-1:0] exp_words [num_words];
        int got;
        // sign of each model counter, tie gives zero
        for (int k = 0; k < num_words; k++) begin
            for (int b = 0; b < stream_w; b++) begin
                exp_words[k][b] = (model_cnt[k * stream_w + b] > 0);
            end
        end
        got = 0;
        @(posedge clk);
        finish_req <= 1'b1;
        stream_ready <= next_ready(bp);
        // a word moves on the edge after valid and ready are both seen
        while (got < num_words) begin
            @(negedge clk);
            if (stream_valid && stream_ready) begin
                check_value("stream_data", stream_data, exp_words[got]);
                check_value("stream_last", stream_last, (got == num_words - 1));
                got++;
            end
            @(posedge clk);
            stream_ready <= next_ready(bp);
        end
        // no extra word before the ack
        @(negedge clk);
        while (!finish_ack) begin
            check_value("stream_valid", stream_valid, 1'b0);
            @(negedge clk);
        end
        @(posedge clk);
        finish_req <= 1'b0;
        stream_ready <= 1'b0;
        do @(negedge clk); while (finish_ack);
        // next bundle starts from zero
        for (int j = 0; j < hv_dim; j++) begin
            model_cnt[j] = 0;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        sample_req = 1'b0;
        sample_symbols = '0;
        sample_shifts = '0;
        sample_mask = '0;
        finish_req = 1'b0;
        stream_ready = 1'b0;
        for (int j = 0; j < hv_dim; j++) begin
            model_cnt[j] = 0;
        end

        // lane 3 first in every slice list
        table_rows[0] = make_row(k_load, '0, '0, 4'b0000, 1'b0);
        // single lane, no rotation
        table_rows[1] = make_row(k_batch, {4'd0, 4'd0, 4'd0, 4'd3},
                                 {6'd0, 6'd0, 6'd0, 6'd0}, 4'b0001, 1'b0);
        table_rows[2] = make_row(k_finish, '0, '0, 4'b0000, 1'b0);
        table_rows[3] = make_row(k_batch, {4'd12, 4'd9, 4'd5, 4'd1},
                                 {6'd63, 6'd33, 6'd0, 6'd7}, 4'b1111, 1'b0);
        table_rows[4] = make_row(k_batch, {4'd11, 4'd7, 4'd2, 4'd2},
                                 {6'd5, 6'd40, 6'd12, 6'd1}, 4'b1111, 1'b0);
        // masked off entirely, must not vote
        table_rows[5] = make_row(k_batch, {4'd10, 4'd8, 4'd6, 4'd4},
                                 {6'd3, 6'd3, 6'd3, 6'd3}, 4'b0000, 1'b0);
        table_rows[6] = make_row(k_batch, {4'd3, 4'd6, 4'd13, 4'd0},
                                 {6'd50, 6'd2, 6'd9, 6'd20}, 4'b1111, 1'b0);
        table_rows[7] = make_row(k_batch, {4'd1, 4'd10, 4'd4, 4'd8},
                                 {6'd44, 6'd0, 6'd31, 6'd17}, 4'b0111, 1'b0);
        table_rows[8] = make_row(k_finish, '0, '0, 4'b0000, 1'b1);
        // item and its complement, every count ends at zero
        table_rows[9] = make_row(k_batch, {4'd0, 4'd0, 4'd15, 4'd14},
                                 {6'd0, 6'd0, 6'd0, 6'd0}, 4'b0011, 1'b0);
        table_rows[10] = make_row(k_finish, '0, '0, 4'b0000, 1'b1);
        table_rows[11] = make_row(k_batch, {4'd9, 4'd0, 4'd7, 4'd0},
                                  {6'd61, 6'd0, 6'd25, 6'd0}, 4'b1010, 1'b0);
        table_rows[12] = make_row(k_batch, {4'd0, 4'd11, 4'd0, 4'd5},
                                  {6'd0, 6'd58, 6'd0, 6'd11}, 4'b0101, 1'b0);
        table_rows[13] = make_row(k_finish, '0, '0, 4'b0000, 1'b0);

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("sample_ack", sample_ack, 1'b0);
        check_value("finish_ack", finish_ack, 1'b0);
        check_value("stream_valid", stream_valid, 1'b0);

        for (int i = 0; i < num_rows; i++) begin
            case (table_rows[i].kind)
                k_load: load_items();
                k_batch: run_batch(table_rows[i]);
                default: run_finish(table_rows[i].bp);
            endcase
        end

        repeat (2) @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* source/hdc_encoder_top.sv */
`timescale 1ns/1ps

module hdc_encoder_top import hdc_cfg_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               load_en,
    input  logic [sym_w-1:0]                   load_addr,
    input  logic [hv_dim-1:0]                  load_data,
    input  logic                               sample_req,
    output logic                               sample_ack,
    input  logic [num_cores-1:0][sym_w-1:0]    sample_symbols,
    input  logic [num_cores-1:0][shift_w-1:0]  sample_shifts,
    input  logic [num_cores-1:0]               sample_mask,
    input  logic                               finish_req,
    output logic                               finish_ack,
    output logic [stream_w-1:0]                stream_data,
    output logic                               stream_valid,
    output logic                               stream_last,
    input  logic                               stream_ready
);

    logic rd_en;
    logic [sym_w-1:0] rd_addr;
    logic [hv_dim-1:0] rd_data;
    logic [num_cores-1:0] core_start;
    logic [num_cores-1:0] core_done;
    logic [num_cores-1:0] core_store;
    logic [num_cores-1:0][hv_dim-1:0] core_results;
    logic bundle_busy;

    // one read bus per lane
    mem_bus_if lane_bus [num_cores] ();

    item_memory u_item_memory (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    mem_arbiter u_mem_arbiter (
        .clk     (clk),
        .rst_n   (rst_n),
        .lanes   (lane_bus),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // symbol and position per lane from the batch
    for (genvar i = 0; i < num_cores; i++) begin : g_core
        hv_encode_core u_core (
            .clk    (clk),
            .rst_n  (rst_n),
            .start  (core_start[i]),
            .symbol (sample_symbols[i]),
            .shift  (sample_shifts[i]),
            .mem    (lane_bus[i]),
            .result (core_results[i]),
            .done   (core_done[i])
        );
    end

    hv_batch_ctrl u_batch_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_req  (sample_req),
        .sample_ack  (sample_ack),
        .sample_mask (sample_mask),
        .start       (core_start),
        .done        (core_done),
        .store       (core_store),
        .bundle_busy (bundle_busy)
    );

    hv_bundler u_bundler (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_results (core_results),
        .store        (core_store),
        .finish_req   (finish_req),
        .finish_ack   (finish_ack),
        .stream_data  (stream_data),
        .stream_valid (stream_valid),
        .stream_last  (stream_last),
        .stream_ready (stream_ready),
        .bundle_busy  (bundle_busy)
    );

endmodule

/* source/hv_bundler.sv */
`timescale 1ns/1ps

module hv_bundler import hdc_cfg_pkg::*, hdc_types_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [num_cores-1:0][hv_dim-1:0]  core_results,
    input  logic [num_cores-1:0]              store,
    input  logic                              finish_req,
    output logic                              finish_ack,
    output logic [stream_w-1:0]               stream_data,
    output logic                              stream_valid,
    output logic                              stream_last,
    input  logic                              stream_ready,
    output logic                              bundle_busy
);

    bundle_state_t state;
    logic [hv_dim-1:0] sign_vec;
    logic [word_w-1:0] word_idx;
    logic clear;

    // counters wiped in the single s_clear cycle
    assign clear = (state == s_clear);

    // finish_req blocks new stores right away
    assign bundle_busy = (state != s_idle) || finish_req;

    // one counter per dimension, fed bit j of every lane
    for (genvar j = 0; j < hv_dim; j++) begin : g_dim
        logic [num_cores-1:0] votes;
        for (genvar i = 0; i < num_cores; i++) begin : g_vote
            assign votes[i] = core_results[i][j];
        end
        hv_bundle_counter u_cnt (
            .clk      (clk),
            .rst_n    (rst_n),
            .clear    (clear),
            .store    (store),
            .votes    (votes),
            .sign_bit (sign_vec[j])
        );
    end

    // counters are frozen while streaming, so this holds under stall
    assign stream_data = sign_vec[int'(word_idx) * stream_w +: stream_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_idle;
            word_idx <= '0;
            stream_valid <= 1'b0;
            stream_last <= 1'b0;
            finish_ack <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    // let a pending store land first
                    if (finish_req && store == '0) begin
                        word_idx <= '0;
                        stream_valid <= 1'b1;
                        stream_last <= (num_words == 1);
                        state <= s_stream;
                    end
                end
                s_stream: begin
                    if (stream_valid && stream_ready) begin
                        if (stream_last) begin
                            stream_valid <= 1'b0;
                            stream_last <= 1'b0;
                            state <= s_clear;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                            stream_last <= (int'(word_idx) + 2 == num_words);
                        end
                    end
                end
                s_clear: begin
                    finish_ack <= 1'b1;
                    state <= s_ack;
                end
                s_ack: begin
                    if (!finish_req) begin
                        finish_ack <= 1'b0;
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        stream_valid && !stream_ready |=>
            stream_valid && $stable(stream_data) && $stable(stream_last));

endmodule

/* source/hv_bundle_counter.sv */
`timescale 1ns/1ps

module hv_bundle_counter import hdc_cfg_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clear,
    input  logic [num_cores-1:0] store,
    input  logic [num_cores-1:0] votes,
    output logic                 sign_bit
);

    logic signed [cnt_w-1:0] cnt;
    logic signed [cnt_w-1:0] cnt_next;

    // +1 for a one vote, -1 for a zero vote, stored lanes only
    always_comb begin
        int sum;
        sum = int'(cnt);
        for (int i = 0; i < num_cores; i++) begin
            if (store[i]) begin
                sum = sum + (votes[i] ? 1 : -1);
            end
        end
        // clamp at the counter range
        if (sum > cnt_max) begin
            sum = cnt_max;
        end else if (sum < cnt_min) begin
            sum = cnt_min;
        end
        cnt_next = cnt_w'(sum);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (clear) begin
            cnt <= '0;
        end else if (store != '0) begin
            cnt <= cnt_next;
        end
    end

    // tie gives zero
    assign sign_bit = (cnt > 0);

endmodule

/* source/hv_batch_ctrl.sv */
`timescale 1ns/1ps

module hv_batch_ctrl import hdc_cfg_pkg::*, hdc_types_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sample_req,
    output logic                 sample_ack,
    input  logic [num_cores-1:0] sample_mask,
    output logic [num_cores-1:0] start,
    input  logic [num_cores-1:0] done,
    output logic [num_cores-1:0] store,
    input  logic                 bundle_busy
);

    batch_state_t state;
    logic all_done;

    // every enabled lane has its result
    assign all_done = ((done & sample_mask) == sample_mask);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= b_idle;
            start <= '0;
            store <= '0;
            sample_ack <= 1'b0;
        end else begin
            // start and store are single-cycle pulses
            start <= '0;
            store <= '0;
            case (state)
                b_idle: begin
                    if (sample_req && !bundle_busy) begin
                        if (sample_mask == '0) begin
                            // nothing to encode, ack at once
                            sample_ack <= 1'b1;
                            state <= b_ack;
                        end else begin
                            start <= sample_mask;
                            state <= b_run;
                        end
                    end
                end
                b_run: begin
                    // done is stale while start is high
                    // bundler must be idle before votes go in
                    if (start == '0 && all_done && !bundle_busy) begin
                        store <= sample_mask;
                        state <= b_store;
                    end
                end
                b_store: begin
                    sample_ack <= 1'b1;
                    state <= b_ack;
                end
                b_ack: begin
                    if (!sample_req) begin
                        sample_ack <= 1'b0;
                        state <= b_idle;
                    end
                end
                default: state <= b_idle;
            endcase
        end
    end

endmodule

/* source/hv_encode_core.sv */
`timescale 1ns/1ps

module hv_encode_core import hdc_cfg_pkg::*, hdc_types_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic [sym_w-1:0]   symbol,
    input  logic [shift_w-1:0] shift,
    mem_bus_if.requester       mem,
    output logic [hv_dim-1:0]  result,
    output logic               done
);

    core_state_t state;
    logic [sym_w-1:0] symbol_q;
    logic [shift_w-1:0] shift_q;
    logic accept;
    logic [2*hv_dim-1:0] rotated;

    // start only counts when not mid-fetch
    assign accept = start && (state == c_idle || state == c_done);

    assign mem.req = (state == c_req);
    assign mem.addr = symbol_q;
    assign done = (state == c_done);

    // rotate left by shift_q, low half of the doubled word
    // shift of zero returns rdata as is
    assign rotated = {mem.rdata, mem.rdata} >> (hv_dim - int'(shift_q));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= c_idle;
        end else begin
            case (state)
                c_idle, c_done: begin
                    if (accept) begin
                        state <= c_req;
                    end
                end
                c_req: begin
                    if (mem.ack) begin
                        state <= c_wait_drop;
                    end
                end
                // hold off until the arbiter drops ack
                c_wait_drop: begin
                    if (!mem.ack) begin
                        state <= c_done;
                    end
                end
                default: state <= c_idle;
            endcase
        end
    end

    // symbol, shift and bound result
    always_ff @(posedge clk) begin
        if (accept) begin
            symbol_q <= symbol;
            shift_q <= shift;
        end
        if (state == c_req && mem.ack) begin
            result <= rotated[hv_dim-1:0];
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem.req && !mem.ack |=> mem.req);

endmodule

/* source/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter import hdc_cfg_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    mem_bus_if.server         lanes [num_cores],
    output logic              rd_en,
    output logic [sym_w-1:0]  rd_addr,
    input  logic [hv_dim-1:0] rd_data
);

    logic [num_cores-1:0] req_vec;
    logic [sym_w-1:0]     addr_arr [num_cores];
    logic [num_cores-1:0] grant;
    logic [lane_w-1:0]    gidx;
    logic [lane_w-1:0]    ptr;
    logic [lane_w-1:0]    pick;
    logic                 pick_ok;
    logic                 rd_pend;
    logic                 ack_q;

    // flatten the interface array
    for (genvar i = 0; i < num_cores; i++) begin : g_lane
        assign req_vec[i] = lanes[i].req;
        assign addr_arr[i] = lanes[i].addr;
        // ack only on the granted lane
        assign lanes[i].ack = ack_q & grant[i];
        assign lanes[i].rdata = rd_data;
    end

    // first requester at or after ptr
    // descending scan so the nearest lane wins
    always_comb begin
        int idx;
        pick = ptr;
        pick_ok = 1'b0;
        for (int k = num_cores - 1; k >= 0; k--) begin
            idx = (int'(ptr) + k) % num_cores;
            if (req_vec[idx]) begin
                pick = lane_w'(idx);
                pick_ok = 1'b1;
            end
        end
    end

    // new read only when no lane holds the bus
    assign rd_en = (grant == '0) && pick_ok;
    assign rd_addr = addr_arr[pick];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant <= '0;
            gidx <= '0;
            ptr <= '0;
            rd_pend <= 1'b0;
            ack_q <= 1'b0;
        end else if (rd_en) begin
            grant <= '0;
            grant[pick] <= 1'b1;
            gidx <= pick;
            rd_pend <= 1'b1;
        end else if (rd_pend) begin
            // memory data is on rd_data now
            rd_pend <= 1'b0;
            ack_q <= 1'b1;
        end else if (ack_q && !req_vec[gidx]) begin
            // lane released req, drop ack and move past it
            ack_q <= 1'b0;
            grant <= '0;
            ptr <= lane_w'((int'(gidx) + 1) % num_cores);
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant));

    // ack rises only for a lane still asking, with the read of its own address
    for (genvar i = 0; i < num_cores; i++) begin : g_ack_chk
        a_ack_to_req: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(lanes[i].ack) |-> lanes[i].req && (lanes[i].addr == $past(rd_addr, 2)));
    end

endmodule

/* source/item_memory.sv */
`timescale 1ns/1ps

module item_memory import hdc_cfg_pkg::*; (
    input  logic              clk,
    input  logic              load_en,
    input  logic [sym_w-1:0]  load_addr,
    input  logic [hv_dim-1:0] load_data,
    input  logic              rd_en,
    input  logic [sym_w-1:0]  rd_addr,
    output logic [hv_dim-1:0] rd_data
);

    // one base hypervector per symbol
    logic [hv_dim-1:0] items [num_items];

    // host load port, one entry per cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            items[load_addr] <= load_data;
        end
    end

    // registered read, data one cycle after rd_en
    // rd_data holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= items[rd_addr];
        end
    end

endmodule

/* source/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if import hdc_cfg_pkg::*; ();

    // four-phase read request from one lane
    logic req;
    logic ack;
    logic [sym_w-1:0] addr;
    // item hypervector, valid while ack is high
    logic [hv_dim-1:0] rdata;

    // core side
    modport requester (
        output req,
        output addr,
        input  ack,
        input  rdata
    );

    // arbiter side
    modport server (
        input  req,
        input  addr,
        output ack,
        output rdata
    );

endinterface

/* source/hdc_types_pkg.sv */
package hdc_types_pkg;

    // encoding core
    // c_wait_drop waits for the arbiter to release ack
    typedef enum logic [1:0] {
        c_idle, c_req, c_wait_drop, c_done
    } core_state_t;

    // sample batch handshake
    typedef enum logic [1:0] {
        b_idle, b_run, b_store, b_ack
    } batch_state_t;

    // finish handshake and sign streaming
    typedef enum logic [1:0] {
        s_idle, s_stream, s_clear, s_ack
    } bundle_state_t;

endpackage

/* source/hdc_cfg_pkg.sv */
package hdc_cfg_pkg;

    // hypervector size
    localparam int hv_dim = 64;

    // encoding lanes sharing the item memory
    localparam int num_cores = 4;
    localparam int lane_w = $clog2(num_cores);

    // symbol index and item memory depth
    localparam int sym_w = 4;
    localparam int num_items = 2 ** sym_w;

    // rotation amount, enough for hv_dim - 1
    localparam int shift_w = 6;

    // signed vote counter, saturating
    localparam int cnt_w = 8;
    localparam int cnt_max = 2 ** (cnt_w - 1) - 1;
    localparam int cnt_min = -(2 ** (cnt_w - 1));

    // output stream words
    localparam int stream_w = 32;
    localparam int num_words = hv_dim / stream_w;
    localparam int word_w = (num_words > 1) ? $clog2(num_words) : 1;

endpackage
